/* hw/glb_param_pkg.sv */
////////////////////
// global buffer tile parameters
// address field widths, bank count and data word width
////////////////////

package glb_param_pkg;

    // word address inside one bank, 64 words
    localparam int BANK_ADDR_WIDTH = 6;

    // bank index field, sits above the word address
    localparam int BANK_SEL_ADDR_WIDTH = 2;

    // one bank per bank-select code
    localparam int BANKS_PER_TILE = 4;

    // tile index field, top of the address
    localparam int TILE_SEL_ADDR_WIDTH = 2;

    // full address as tile | bank | word
    localparam int GLB_ADDR_WIDTH = TILE_SEL_ADDR_WIDTH
                                  + BANK_SEL_ADDR_WIDTH
                                  + BANK_ADDR_WIDTH;

    // one data word
    localparam int DATA_WIDTH = 16;

endpackage

/* hw/glb_packet_pkg.sv */
////////////////////
// global buffer packet types
// address and data vectors, packet structs
// and the read-source code of the switch
////////////////////

package glb_packet_pkg;

    // vectors sized by the tile address map
    typedef logic [glb_param_pkg::GLB_ADDR_WIDTH-1:0]      glb_addr_t;
    typedef logic [glb_param_pkg::DATA_WIDTH-1:0]          glb_data_t;
    typedef logic [glb_param_pkg::TILE_SEL_ADDR_WIDTH-1:0] tile_id_t;
    typedef logic [glb_param_pkg::BANK_SEL_ADDR_WIDTH-1:0] bank_sel_t;
    typedef logic [glb_param_pkg::BANK_ADDR_WIDTH-1:0]     bank_addr_t;

    // write packet, 27 bits
    typedef struct packed {
        logic      wr_en;
        glb_addr_t wr_addr;
        glb_data_t wr_data;
    } wr_packet_t;

    // read request packet, 11 bits
    typedef struct packed {
        logic      rd_en;
        glb_addr_t rd_addr;
    } rdrq_packet_t;

    // read response packet, 17 bits
    typedef struct packed {
        logic      rd_data_valid;
        glb_data_t rd_data;
    } rdrs_packet_t;

    // which requester owns a read in flight
    typedef enum logic [2:0] {
        src_none     = 3'd0,
        src_proc     = 3'd1,
        src_strm_dma = 3'd2,
        src_strm_rtr = 3'd3,
        src_cfg      = 3'd4
    } rdrq_src_t;

endpackage

/* hw/glb_bank.sv */
////////////////////
// global buffer bank
// single-port style SRAM word array,
// registered read data with a valid flag
////////////////////
`timescale 1ns/1ns

module glb_bank (
    input  logic                          clk,
    input  logic                          clk_en,
    input  logic                          reset,
    input  logic                          wr_en,
    input  logic                          rd_en,
    input  glb_packet_pkg::bank_addr_t    wr_addr,
    input  glb_packet_pkg::bank_addr_t    rd_addr,
    input  glb_packet_pkg::glb_data_t     wr_data,
    output glb_packet_pkg::rdrs_packet_t  rdrs_packet
);

    localparam int BANK_DEPTH = 2 ** glb_param_pkg::BANK_ADDR_WIDTH;

    glb_packet_pkg::glb_data_t mem [BANK_DEPTH];

    // storage
    always_ff @(posedge clk) begin
        if (clk_en && wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, same-cycle write gives the old word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrs_packet <= '0;
        end else if (clk_en) begin
            rdrs_packet.rd_data_valid <= rd_en;
            if (rd_en) begin
                rdrs_packet.rd_data <= mem[rd_addr];
            end
        end
    end

endmodule

/* hw/glb_bank_demux.sv */
////////////////////
// bank demux
// turns the switched write and read request
// into per-bank enables and word addresses
////////////////////
`timescale 1ns/1ns

module glb_bank_demux (
    input  glb_packet_pkg::wr_packet_t              wr_packet,
    input  glb_packet_pkg::rdrq_packet_t            rdrq_packet,
    output logic [glb_param_pkg::BANKS_PER_TILE-1:0] bank_wr_en,
    output logic [glb_param_pkg::BANKS_PER_TILE-1:0] bank_rd_en,
    output glb_packet_pkg::bank_addr_t              bank_wr_addr,
    output glb_packet_pkg::bank_addr_t              bank_rd_addr,
    output glb_packet_pkg::glb_data_t               bank_wr_data
);

    glb_packet_pkg::bank_sel_t wr_bank_sel;
    glb_packet_pkg::bank_sel_t rd_bank_sel;

    // bank field sits right above the word address
    assign wr_bank_sel = wr_packet.wr_addr[glb_param_pkg::BANK_ADDR_WIDTH
                                           +: glb_param_pkg::BANK_SEL_ADDR_WIDTH];
    assign rd_bank_sel = rdrq_packet.rd_addr[glb_param_pkg::BANK_ADDR_WIDTH
                                             +: glb_param_pkg::BANK_SEL_ADDR_WIDTH];

    // one-hot enables, tile already checked upstream
    always_comb begin
        bank_wr_en = '0;
        bank_rd_en = '0;
        if (wr_packet.wr_en) begin
            bank_wr_en[wr_bank_sel] = 1'b1;
        end
        if (rdrq_packet.rd_en) begin
            bank_rd_en[rd_bank_sel] = 1'b1;
        end
    end

    // all banks share the word address and data
    assign bank_wr_addr = wr_packet.wr_addr[glb_param_pkg::BANK_ADDR_WIDTH-1:0];
    assign bank_rd_addr = rdrq_packet.rd_addr[glb_param_pkg::BANK_ADDR_WIDTH-1:0];
    assign bank_wr_data = wr_packet.wr_data;

endmodule

/* hw/glb_core_switch.sv */
////////////////////
// global buffer core channel switch
// arbitrates writes and read requests from four sources,
// keeps packets for this tile and steers the bank
// responses back to the requester
////////////////////
`timescale 1ns/1ns

module glb_core_switch (
    input  logic                           clk,
    input  logic                           clk_en,
    input  logic                           reset,
    input  glb_packet_pkg::tile_id_t       glb_tile_id,
    input  logic                           cfg_store_dma_on,
    input  logic                           cfg_load_dma_on,

    // write packets
    input  glb_packet_pkg::wr_packet_t     wr_packet_sr2sw,
    input  glb_packet_pkg::wr_packet_t     wr_packet_pr2sw,
    input  glb_packet_pkg::wr_packet_t     wr_packet_d2sw,
    output glb_packet_pkg::wr_packet_t     wr_packet_sw2sr,
    output glb_packet_pkg::wr_packet_t     wr_packet_sw2b,

    // read request packets
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_sr2sw,
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_pr2sw,
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_pc2sw,
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_d2sw,
    output glb_packet_pkg::rdrq_packet_t   rdrq_packet_sw2sr,
    output glb_packet_pkg::rdrq_packet_t   rdrq_packet_sw2b,

    // read response packets
    input  glb_packet_pkg::rdrs_packet_t   rdrs_packet_sr2sw,
    input  glb_packet_pkg::rdrs_packet_t   rdrs_packet_b2sw_arr [glb_param_pkg::BANKS_PER_TILE],
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_sw2pr,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_sw2pc,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_sw2sr,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_sw2d
);

    // field offsets inside the full address
    localparam int BANK_SEL_LSB = glb_param_pkg::BANK_ADDR_WIDTH;
    localparam int TILE_LSB     = glb_param_pkg::BANK_ADDR_WIDTH
                                + glb_param_pkg::BANK_SEL_ADDR_WIDTH;

    glb_packet_pkg::wr_packet_t   wr_muxed;
    glb_packet_pkg::wr_packet_t   wr_filtered;

    glb_packet_pkg::rdrq_src_t    rdrq_src_muxed;
    glb_packet_pkg::rdrq_packet_t rdrq_muxed;
    glb_packet_pkg::bank_sel_t    rdrq_bank_muxed;

    // source and bank of each read, one entry per pipeline stage
    glb_packet_pkg::rdrq_src_t    src_s1, src_s2, src_s3;
    glb_packet_pkg::bank_sel_t    bank_s1, bank_s2, bank_s3;

    glb_packet_pkg::rdrs_packet_t rdrs_b2sw_q [glb_param_pkg::BANKS_PER_TILE];
    glb_packet_pkg::rdrs_packet_t rdrs_selected;

    function automatic logic in_tile(
        input glb_packet_pkg::glb_addr_t addr,
        input glb_packet_pkg::tile_id_t  id
    );
        return addr[TILE_LSB +: glb_param_pkg::TILE_SEL_ADDR_WIDTH] == id;
    endfunction

    // write arbitration, processor first
    always_comb begin
        if (wr_packet_pr2sw.wr_en) begin
            wr_muxed = wr_packet_pr2sw;
        end else if (cfg_store_dma_on) begin
            wr_muxed = wr_packet_d2sw;
        end else begin
            wr_muxed = wr_packet_sr2sw;
        end
    end

    // other tiles' writes turn into an empty packet
    assign wr_filtered = in_tile(wr_muxed.wr_addr, glb_tile_id) ? wr_muxed : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_packet_sw2b <= '0;
        end else if (clk_en) begin
            wr_packet_sw2b <= wr_filtered;
        end
    end

    // stream pass-through to the next router hop
    assign wr_packet_sw2sr = cfg_store_dma_on ? wr_packet_d2sw : wr_packet_sr2sw;

    // read arbitration, each source must hit this tile
    always_comb begin
        if (rdrq_packet_pr2sw.rd_en && in_tile(rdrq_packet_pr2sw.rd_addr, glb_tile_id)) begin
            rdrq_src_muxed = glb_packet_pkg::src_proc;
        end else if (cfg_load_dma_on && rdrq_packet_d2sw.rd_en
                     && in_tile(rdrq_packet_d2sw.rd_addr, glb_tile_id)) begin
            rdrq_src_muxed = glb_packet_pkg::src_strm_dma;
        end else if (!cfg_load_dma_on && rdrq_packet_sr2sw.rd_en
                     && in_tile(rdrq_packet_sr2sw.rd_addr, glb_tile_id)) begin
            rdrq_src_muxed = glb_packet_pkg::src_strm_rtr;
        end else if (rdrq_packet_pc2sw.rd_en && in_tile(rdrq_packet_pc2sw.rd_addr, glb_tile_id)) begin
            rdrq_src_muxed = glb_packet_pkg::src_cfg;
        end else begin
            rdrq_src_muxed = glb_packet_pkg::src_none;
        end
    end

    always_comb begin
        case (rdrq_src_muxed)
            glb_packet_pkg::src_proc:     rdrq_muxed = rdrq_packet_pr2sw;
            glb_packet_pkg::src_strm_dma: rdrq_muxed = rdrq_packet_d2sw;
            glb_packet_pkg::src_strm_rtr: rdrq_muxed = rdrq_packet_sr2sw;
            glb_packet_pkg::src_cfg:      rdrq_muxed = rdrq_packet_pc2sw;
            default:                      rdrq_muxed = '0;
        endcase
    end

    assign rdrq_bank_muxed =
        rdrq_muxed.rd_addr[BANK_SEL_LSB +: glb_param_pkg::BANK_SEL_ADDR_WIDTH];

    // stage 1 goes out to the banks together with the request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrq_packet_sw2b <= '0;
            src_s1 <= glb_packet_pkg::src_none;
            bank_s1 <= '0;
        end else if (clk_en) begin
            rdrq_packet_sw2b <= rdrq_muxed;
            src_s1 <= rdrq_src_muxed;
            bank_s1 <= rdrq_bank_muxed;
        end
    end

    assign rdrq_packet_sw2sr = cfg_load_dma_on ? rdrq_packet_d2sw : rdrq_packet_sr2sw;

    // stages 2 and 3 follow the bank and the response register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            src_s2 <= glb_packet_pkg::src_none;
            src_s3 <= glb_packet_pkg::src_none;
            bank_s2 <= '0;
            bank_s3 <= '0;
        end else if (clk_en) begin
            src_s2 <= src_s1;
            src_s3 <= src_s2;
            bank_s2 <= bank_s1;
            bank_s3 <= bank_s2;
        end
    end

    // retime the bank responses
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < glb_param_pkg::BANKS_PER_TILE; i++) begin
                rdrs_b2sw_q[i] <= '0;
            end
        end else if (clk_en) begin
            for (int i = 0; i < glb_param_pkg::BANKS_PER_TILE; i++) begin
                rdrs_b2sw_q[i] <= rdrs_packet_b2sw_arr[i];
            end
        end
    end

    assign rdrs_selected = rdrs_b2sw_q[bank_s3];

    // response steering by the delayed source
    always_comb begin
        rdrs_packet_sw2pr = '0;
        rdrs_packet_sw2pc = '0;
        rdrs_packet_sw2sr = rdrs_packet_sr2sw;
        case (src_s3)
            glb_packet_pkg::src_proc:     rdrs_packet_sw2pr = rdrs_selected;
            glb_packet_pkg::src_cfg:      rdrs_packet_sw2pc = rdrs_selected;
            glb_packet_pkg::src_strm_dma,
            glb_packet_pkg::src_strm_rtr: rdrs_packet_sw2sr = rdrs_selected;
            default: ;
        endcase
    end

    // DMA only listens to the chain while it loads
    assign rdrs_packet_sw2d = cfg_load_dma_on ? rdrs_packet_sr2sw : '0;

endmodule

/* hw/glb_tile_core.sv */
////////////////////
// global buffer tile core
// channel switch, bank demux and bank array
////////////////////
`timescale 1ns/1ns

module glb_tile_core (
    input  logic                           clk,
    input  logic                           clk_en,
    input  logic                           reset,
    input  glb_packet_pkg::tile_id_t       glb_tile_id,
    input  logic                           cfg_store_dma_on,
    input  logic                           cfg_load_dma_on,

    // write packets
    input  glb_packet_pkg::wr_packet_t     wr_packet_sr2sw,
    input  glb_packet_pkg::wr_packet_t     wr_packet_pr2sw,
    input  glb_packet_pkg::wr_packet_t     wr_packet_d2sw,
    output glb_packet_pkg::wr_packet_t     wr_packet_sw2sr,

    // read request packets
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_sr2sw,
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_pr2sw,
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_pc2sw,
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_d2sw,
    output glb_packet_pkg::rdrq_packet_t   rdrq_packet_sw2sr,

    // read response packets
    input  glb_packet_pkg::rdrs_packet_t   rdrs_packet_sr2sw,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_sw2pr,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_sw2pc,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_sw2sr,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_sw2d
);

    // switch to bank side
    glb_packet_pkg::wr_packet_t   wr_packet_sw2b;
    glb_packet_pkg::rdrq_packet_t rdrq_packet_sw2b;
    glb_packet_pkg::rdrs_packet_t rdrs_packet_b2sw_arr [glb_param_pkg::BANKS_PER_TILE];

    logic [glb_param_pkg::BANKS_PER_TILE-1:0] bank_wr_en;
    logic [glb_param_pkg::BANKS_PER_TILE-1:0] bank_rd_en;
    glb_packet_pkg::bank_addr_t               bank_wr_addr;
    glb_packet_pkg::bank_addr_t               bank_rd_addr;
    glb_packet_pkg::glb_data_t                bank_wr_data;

    glb_core_switch i_switch (
        .clk                  (clk),
        .clk_en               (clk_en),
        .reset                (reset),
        .glb_tile_id          (glb_tile_id),
        .cfg_store_dma_on     (cfg_store_dma_on),
        .cfg_load_dma_on      (cfg_load_dma_on),
        .wr_packet_sr2sw      (wr_packet_sr2sw),
        .wr_packet_pr2sw      (wr_packet_pr2sw),
        .wr_packet_d2sw       (wr_packet_d2sw),
        .wr_packet_sw2sr      (wr_packet_sw2sr),
        .wr_packet_sw2b       (wr_packet_sw2b),
        .rdrq_packet_sr2sw    (rdrq_packet_sr2sw),
        .rdrq_packet_pr2sw    (rdrq_packet_pr2sw),
        .rdrq_packet_pc2sw    (rdrq_packet_pc2sw),
        .rdrq_packet_d2sw     (rdrq_packet_d2sw),
        .rdrq_packet_sw2sr    (rdrq_packet_sw2sr),
        .rdrq_packet_sw2b     (rdrq_packet_sw2b),
        .rdrs_packet_sr2sw    (rdrs_packet_sr2sw),
        .rdrs_packet_b2sw_arr (rdrs_packet_b2sw_arr),
        .rdrs_packet_sw2pr    (rdrs_packet_sw2pr),
        .rdrs_packet_sw2pc    (rdrs_packet_sw2pc),
        .rdrs_packet_sw2sr    (rdrs_packet_sw2sr),
        .rdrs_packet_sw2d     (rdrs_packet_sw2d)
    );

    glb_bank_demux i_demux (
        .wr_packet    (wr_packet_sw2b),
        .rdrq_packet  (rdrq_packet_sw2b),
        .bank_wr_en   (bank_wr_en),
        .bank_rd_en   (bank_rd_en),
        .bank_wr_addr (bank_wr_addr),
        .bank_rd_addr (bank_rd_addr),
        .bank_wr_data (bank_wr_data)
    );

    // bank array, enables from the demux
    for (genvar i = 0; i < glb_param_pkg::BANKS_PER_TILE; i++) begin : g_bank
        glb_bank i_bank (
            .clk         (clk),
            .clk_en      (clk_en),
            .reset       (reset),
            .wr_en       (bank_wr_en[i]),
            .rd_en       (bank_rd_en[i]),
            .wr_addr     (bank_wr_addr),
            .rd_addr     (bank_rd_addr),
            .wr_data     (bank_wr_data),
            .rdrs_packet (rdrs_packet_b2sw_arr[i])
        );
    end

endmodule

/* tb/glb_tile_model.svh */
////////////////////
// reference model of the tile core
// shadow memory, tile match and the two priority rules
////////////////////
`ifndef GLB_TILE_MODEL_SVH
`define GLB_TILE_MODEL_SVH

// read source codes, same order as rdrq_src_t
localparam int SRC_NONE = 0;
localparam int SRC_PROC = 1;
localparam int SRC_DMA  = 2;
localparam int SRC_RTR  = 3;
localparam int SRC_CFG  = 4;

// shadow of the tile memory, indexed by the full address
glb_packet_pkg::glb_data_t shadow_mem [2 ** glb_param_pkg::GLB_ADDR_WIDTH];

// tile field is the top of the address
function automatic logic addr_hits_tile(input glb_packet_pkg::glb_addr_t addr,
                                        input glb_packet_pkg::tile_id_t id);
    return addr[glb_param_pkg::GLB_ADDR_WIDTH-1 -: glb_param_pkg::TILE_SEL_ADDR_WIDTH] == id;
endfunction

// processor first, then DMA or router by cfg_store_dma_on, then the tile filter
function automatic glb_packet_pkg::wr_packet_t expected_write_winner(
    input glb_packet_pkg::wr_packet_t pr, d, sr,
    input logic store_on,
    input glb_packet_pkg::tile_id_t id
);
    glb_packet_pkg::wr_packet_t w;
    w = pr.wr_en ? pr : (store_on ? d : sr);
    return addr_hits_tile(w.wr_addr, id) ? w : '0;
endfunction

// processor, DMA while loading, router otherwise, config port last
function automatic int expected_read_source(
    input glb_packet_pkg::rdrq_packet_t pr, d, sr, pc,
    input logic load_on,
    input glb_packet_pkg::tile_id_t id
);
    if (pr.rd_en && addr_hits_tile(pr.rd_addr, id)) begin
        return SRC_PROC;
    end
    if (load_on && d.rd_en && addr_hits_tile(d.rd_addr, id)) begin
        return SRC_DMA;
    end
    if (!load_on && sr.rd_en && addr_hits_tile(sr.rd_addr, id)) begin
        return SRC_RTR;
    end
    if (pc.rd_en && addr_hits_tile(pc.rd_addr, id)) begin
        return SRC_CFG;
    end
    return SRC_NONE;
endfunction

function automatic glb_packet_pkg::glb_data_t expected_rdata(
    input glb_packet_pkg::glb_addr_t addr
);
    return shadow_mem[addr];
endfunction

task automatic store_write(input glb_packet_pkg::wr_packet_t w);
    if (w.wr_en) begin
        shadow_mem[w.wr_addr] = w.wr_data;
    end
endtask

`endif

/* tb/glb_tile_tb.sv */
////////////////////
// testbench for the global buffer tile core
// plays every requester and checks all switch outputs
// against the reference model each cycle
////////////////////
`timescale 1ns/1ns

module glb_tile_tb;

    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int LATENCY       = 3;
    localparam int DRAIN_TIMEOUT = 16;
    localparam int RUN_LIMIT     = 5000;
    localparam int LOCAL_WIDTH   = glb_param_pkg::BANK_SEL_ADDR_WIDTH
                                 + glb_param_pkg::BANK_ADDR_WIDTH;
    localparam glb_packet_pkg::tile_id_t TILE_ID = 2'd2;

    // response ports of the switch
    localparam logic [1:0] PORT_PR = 2'd0;
    localparam logic [1:0] PORT_PC = 2'd1;
    localparam logic [1:0] PORT_SR = 2'd2;

    typedef struct packed {
        int unsigned               due;
        logic [1:0]                port;
        glb_packet_pkg::glb_data_t data;
    } expect_t;

    logic clk, clk_en, reset, cfg_store_dma_on, cfg_load_dma_on, checking;
    glb_packet_pkg::tile_id_t     glb_tile_id;
    glb_packet_pkg::wr_packet_t   wr_packet_sr2sw, wr_packet_pr2sw, wr_packet_d2sw;
    glb_packet_pkg::wr_packet_t   wr_packet_sw2sr;
    glb_packet_pkg::rdrq_packet_t rdrq_packet_sr2sw, rdrq_packet_pr2sw, rdrq_packet_pc2sw;
    glb_packet_pkg::rdrq_packet_t rdrq_packet_d2sw, rdrq_packet_sw2sr;
    glb_packet_pkg::rdrs_packet_t rdrs_packet_sr2sw, rdrs_packet_sw2pr, rdrs_packet_sw2pc;
    glb_packet_pkg::rdrs_packet_t rdrs_packet_sw2sr, rdrs_packet_sw2d;
    int unsigned en_count;
    expect_t     exp_q [$];

    `include "glb_tile_model.svh"

    glb_tile_core i_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // enabled edges since reset, the time base of all responses
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            en_count <= 0;
        end else if (clk_en) begin
            en_count <= en_count + 1;
        end
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("run did not finish within %0d cycles", RUN_LIMIT);
        $display("TEST FAILED");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic glb_packet_pkg::glb_addr_t other_tile(input glb_packet_pkg::glb_addr_t addr);
        glb_packet_pkg::tile_id_t flip;
        flip = glb_packet_pkg::tile_id_t'($urandom_range(3, 1));
        return addr ^ {flip, LOCAL_WIDTH'(0)};
    endfunction

    function automatic glb_packet_pkg::glb_addr_t rand_addr(input logic hit);
        glb_packet_pkg::glb_addr_t addr;
        addr = {TILE_ID, LOCAL_WIDTH'($urandom)};
        return hit ? addr : other_tile(addr);
    endfunction

    // one in four aims at another tile
    function automatic glb_packet_pkg::glb_addr_t maybe_other_tile(
        input glb_packet_pkg::glb_addr_t addr
    );
        return ($urandom_range(3, 0) == 0) ? other_tile(addr) : addr;
    endfunction

    function automatic glb_packet_pkg::wr_packet_t wr_pkt(input glb_packet_pkg::glb_addr_t addr,
                                                          input logic en);
        glb_packet_pkg::wr_packet_t p;
        p.wr_en = en;
        p.wr_addr = addr;
        p.wr_data = glb_packet_pkg::glb_data_t'($urandom);
        return p;
    endfunction

    function automatic glb_packet_pkg::rdrq_packet_t rd_pkt(input glb_packet_pkg::glb_addr_t addr,
                                                            input logic en);
        glb_packet_pkg::rdrq_packet_t p;
        p.rd_en = en;
        p.rd_addr = addr;
        return p;
    endfunction

    task automatic clear_packets();
        wr_packet_sr2sw = '0;
        wr_packet_pr2sw = '0;
        wr_packet_d2sw = '0;
        rdrq_packet_sr2sw = '0;
        rdrq_packet_pr2sw = '0;
        rdrq_packet_pc2sw = '0;
        rdrq_packet_d2sw = '0;
        rdrs_packet_sr2sw = '0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        clk_en = 1'b1;
        clear_packets();
    endtask

    // read sees memory before this cycle's write
    task automatic predict_cycle();
        int src;
        glb_packet_pkg::rdrq_packet_t rq;
        expect_t e;
        if (clk_en) begin
            src = expected_read_source(rdrq_packet_pr2sw, rdrq_packet_d2sw, rdrq_packet_sr2sw,
                                       rdrq_packet_pc2sw, cfg_load_dma_on, TILE_ID);
            case (src)
                SRC_PROC: rq = rdrq_packet_pr2sw;
                SRC_DMA:  rq = rdrq_packet_d2sw;
                SRC_RTR:  rq = rdrq_packet_sr2sw;
                default:  rq = rdrq_packet_pc2sw;
            endcase
            if (src != SRC_NONE) begin
                e.due = en_count + LATENCY;
                e.port = (src == SRC_PROC) ? PORT_PR : (src == SRC_CFG) ? PORT_PC : PORT_SR;
                e.data = expected_rdata(rq.rd_addr);
                exp_q.push_back(e);
            end
            store_write(expected_write_winner(wr_packet_pr2sw, wr_packet_d2sw, wr_packet_sr2sw,
                                              cfg_store_dma_on, TILE_ID));
        end
    endtask

    task automatic compare_outputs();
        glb_packet_pkg::rdrs_packet_t exp_pr, exp_pc, exp_sr, exp_d;
        exp_pr = '0;
        exp_pc = '0;
        exp_sr = rdrs_packet_sr2sw;
        exp_d = cfg_load_dma_on ? rdrs_packet_sr2sw : '0;
        while (exp_q.size() > 0 && exp_q[0].due < en_count) begin
            void'(exp_q.pop_front());
        end
        // a response holds until the next enabled edge
        if (exp_q.size() > 0 && exp_q[0].due == en_count) begin
            case (exp_q[0].port)
                PORT_PR: exp_pr = {1'b1, exp_q[0].data};
                PORT_PC: exp_pc = {1'b1, exp_q[0].data};
                default: exp_sr = {1'b1, exp_q[0].data};
            endcase
        end
        check_value("rdrs_packet_sw2pr", rdrs_packet_sw2pr, exp_pr);
        check_value("rdrs_packet_sw2pc", rdrs_packet_sw2pc, exp_pc);
        check_value("rdrs_packet_sw2sr", rdrs_packet_sw2sr, exp_sr);
        check_value("rdrs_packet_sw2d", rdrs_packet_sw2d, exp_d);
        check_value("wr_packet_sw2sr", wr_packet_sw2sr,
                    cfg_store_dma_on ? wr_packet_d2sw : wr_packet_sr2sw);
        check_value("rdrq_packet_sw2sr", rdrq_packet_sw2sr,
                    cfg_load_dma_on ? rdrq_packet_d2sw : rdrq_packet_sr2sw);
    endtask

    always @(negedge clk) begin
        if (checking) begin
            compare_outputs();
        end
    end

    initial begin
        glb_packet_pkg::glb_addr_t addr;
        int span;
        int waited;
        void'($urandom(32'h6f3b_161f));
        clk_en = 1'b1;
        reset = 1'b1;
        checking = 1'b0;
        glb_tile_id = TILE_ID;
        cfg_store_dma_on = 1'b0;
        cfg_load_dma_on = 1'b0;
        clear_packets();
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        checking = 1'b1;

        // idle after reset, then fill the whole tile from the processor
        repeat (4) next_cycle();
        for (int i = 0; i < 2 ** LOCAL_WIDTH; i++) begin
            next_cycle();
            wr_packet_pr2sw = wr_pkt({TILE_ID, LOCAL_WIDTH'(i)}, 1'b1);
            predict_cycle();
        end
        repeat (64) begin
            next_cycle();
            rdrq_packet_pr2sw = rd_pkt(rand_addr(1'b1), 1'b1);
            predict_cycle();
        end

        // foreign tile traffic, then read the same local word here
        repeat (32) begin
            addr = rand_addr(1'b1);
            next_cycle();
            wr_packet_pr2sw = wr_pkt(other_tile(addr), 1'b1);
            rdrq_packet_pc2sw = rd_pkt(other_tile(addr), 1'b1);
            predict_cycle();
            next_cycle();
            rdrq_packet_pr2sw = rd_pkt(addr, 1'b1);
            predict_cycle();
        end

        // three writers on one word, read back the winner
        repeat (64) begin
            addr = rand_addr(1'b1);
            next_cycle();
            cfg_store_dma_on = $urandom_range(1, 0);
            wr_packet_pr2sw = wr_pkt(maybe_other_tile(addr), $urandom_range(1, 0));
            wr_packet_d2sw = wr_pkt(maybe_other_tile(addr), $urandom_range(1, 0));
            wr_packet_sr2sw = wr_pkt(maybe_other_tile(addr), $urandom_range(1, 0));
            predict_cycle();
            next_cycle();
            rdrq_packet_pr2sw = rd_pkt(addr, 1'b1);
            predict_cycle();
        end

        // competing readers and a busy router response input
        repeat (96) begin
            next_cycle();
            cfg_load_dma_on = $urandom_range(1, 0);
            rdrq_packet_pr2sw = rd_pkt(rand_addr($urandom_range(3, 0) != 0),
                                       $urandom_range(3, 0) == 0);
            rdrq_packet_d2sw = rd_pkt(rand_addr($urandom_range(3, 0) != 0), $urandom_range(1, 0));
            rdrq_packet_sr2sw = rd_pkt(rand_addr($urandom_range(3, 0) != 0), $urandom_range(1, 0));
            rdrq_packet_pc2sw = rd_pkt(rand_addr($urandom_range(3, 0) != 0), $urandom_range(1, 0));
            rdrs_packet_sr2sw = glb_packet_pkg::rdrs_packet_t'($urandom);
            predict_cycle();
        end

        // clock enable gaps over a small address pool
        cfg_load_dma_on = 1'b1;
        span = 0;
        repeat (200) begin
            next_cycle();
            if (span == 0 && $urandom_range(3, 0) == 0) begin
                span = $urandom_range(5, 1);
            end
            addr = rand_addr(1'b1);
            addr[glb_param_pkg::BANK_ADDR_WIDTH-1:2] = '0;
            if (span > 0) begin
                clk_en = 1'b0;
                span--;
            end else begin
                case ($urandom_range(2, 0))
                    0:       wr_packet_pr2sw = wr_pkt(addr, 1'b1);
                    1:       rdrq_packet_pr2sw = rd_pkt(addr, 1'b1);
                    default: rdrq_packet_d2sw = rd_pkt(addr, 1'b1);
                endcase
            end
            predict_cycle();
        end

        // let the pipeline empty
        waited = 0;
        next_cycle();
        while (exp_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("%0d responses still outstanding after the drain", exp_q.size());
            $display("TEST FAILED");
            $fatal(1);
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

/* project.f */
+incdir+tb
hw/glb_param_pkg.sv
hw/glb_packet_pkg.sv
hw/glb_bank.sv
hw/glb_bank_demux.sv
hw/glb_core_switch.sv
hw/glb_tile_core.sv
tb/glb_tile_tb.sv
